// File: dv/camera_stream_checker.sv
// Camera stream assertions
// Bound into the top level, watches the buffer write strobe and word

module camera_stream_checker (
  input logic                ccd_pixel_clk,
  input logic                rst,
  input logic                fifo_write,
  input cam_pkg::fifo_word_u fifo_word
);

  int assert_fails = 0;  // Failed assertion total

  // ============================================================
  // Write strobe
  // ============================================================
  // Strobe held low while in reset
  write_in_reset: assert property (@(posedge ccd_pixel_clk) rst |=> !fifo_write)
    else begin
      assert_fails++;
      $error("fifo_write high in reset");
    end

  // Each block spans two raw columns, so writes never come back to back,
  // not even across a line wrap
  write_spacing: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    fifo_write |=> !fifo_write)
    else begin
      assert_fails++;
      $error("fifo_write high on two adjacent cycles");
    end

  // ============================================================
  // Word format
  // ============================================================
  high_bit_clear: assert property (@(posedge ccd_pixel_clk) disable iff (rst)
    fifo_write |-> !fifo_word.rgb555.zero)  // Top bit is zero in both views
    else begin
      assert_fails++;
      $error("Top bit of buffer word set");
    end

endmodule

// File: dv/camera_stream_tb.sv
// Camera stream testbench
// Random 8x6 Bayer frames through the pixel path, words checked against a
// reference model, plus frame count, frame rate and start gating

module camera_stream_tb;

  localparam int     frame_w        = 8;     // Raw samples per line
  localparam int     frame_h        = 6;     // Raw lines per frame
  localparam int     clk_period     = 10;
  localparam int     rate_window    = 600;   // Shortened window for simulation
  localparam int     n_frames       = 16;
  localparam int     frame_len_max  = 100;   // Cycles, gaps included
  localparam int     watchdog_time  = n_frames * frame_len_max * 3 * clk_period;
  localparam longint half_period    = longint'(clk_period / 2);
  localparam longint count_delay    = longint'(2 * clk_period);  // Frame end to count
  localparam longint window_len     = longint'(rate_window * clk_period);

  logic                       ccd_pixel_clk;
  logic                       por_rst;
  logic                       mid_rst;
  logic                       rst;
  cam_pkg::cam_pins_t         pins;
  logic                       start;
  logic                       mode_rgb;
  cam_pkg::frame_size_t       frame_size;
  cam_pkg::color_thresholds_t thresholds;
  cam_pkg::fifo_word_u        fifo_word;
  logic                       fifo_write;
  cam_pkg::frame_count_t      frame_count;
  cam_pkg::frame_count_t      frame_rate;
  logic                       rate_toggle;

  cam_pkg::fifo_word_u   exp_q [$];      // Words still to come, raster order
  longint                end_times [$];  // Edge times of expected count steps
  cam_pkg::frame_count_t exp_frames = '0;
  logic                  rst_prev   = 1'b1;  // Reset as seen by the last edge
  int live_edges   = 0;                      // Edges since reset release
  int word_errors  = 0;
  int count_errors = 0;
  int flag_errors  = 0;
  int other_errors = 0;

  assign rst = por_rst | mid_rst;

  tb_clock_gen u_clk (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (por_rst)
  );

  camera_stream_top #(
    .rate_window (rate_window)
  ) uut (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .pins          (pins),
    .start         (start),
    .mode_rgb      (mode_rgb),
    .frame_size    (frame_size),
    .thresholds    (thresholds),
    .fifo_word     (fifo_word),
    .fifo_write    (fifo_write),
    .frame_count   (frame_count),
    .frame_rate    (frame_rate),
    .rate_toggle   (rate_toggle)
  );

  bind camera_stream_top camera_stream_checker u_checker (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .fifo_write    (fifo_write),
    .fifo_word     (fifo_word)
  );

  // ============================================================
  // Reference model and compare tasks
  // ============================================================
  // One 2x2 block: G1 R on top, B G2 below
  function automatic cam_pkg::fifo_word_u expected_word(
    input logic [cam_pkg::raw_w-1:0] g1,
    input logic [cam_pkg::raw_w-1:0] r,
    input logic [cam_pkg::raw_w-1:0] b,
    input logic [cam_pkg::raw_w-1:0] g2,
    input logic                      rgb,
    input cam_pkg::color_thresholds_t th
  );
    int                  gmean;
    cam_pkg::fifo_word_u w;
    gmean = (int'(g1) + int'(g2)) / 2;  // Floor of the mean
    w = '0;
    if (rgb) begin
      w.rgb555 = '{zero: 1'b0, red5: 5'(int'(r) / 128), green5: 5'(gmean / 128),
                   blue5: 5'(int'(b) / 128)};
    end else if (int'(r) / 16 >= int'(th.red_min) && gmean / 16 <= int'(th.green_max)
                 && int'(b) / 16 <= int'(th.blue_max)) begin
      w.mask = '{zero_byte: 8'h00, mask_byte: 8'hff};
    end
    return w;
  endfunction

  task automatic check_word(input string name, input cam_pkg::fifo_word_u got,
                            input cam_pkg::fifo_word_u exp);
    if (got !== exp) begin
      word_errors++;
      $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input cam_pkg::frame_count_t got,
                             input cam_pkg::frame_count_t exp);
    if (got !== exp) begin
      count_errors++;
      $display("Mismatch at time %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("Mismatch at time %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ============================================================
  // Stimulus
  // ============================================================
  task automatic line_gap(input int n);
    repeat (n) begin
      @(posedge ccd_pixel_clk);
      pins.line_valid <= 1'b0;
      pins.data       <= cam_pkg::raw_w'($urandom);  // Junk between lines
    end
  endtask

  task automatic check_reset_state();
    check_flag("fifo_write", fifo_write, 1'b0);
    check_count("frame_count", frame_count, '0);
    check_count("frame_rate", frame_rate, '0);
  endtask

  // start_at_frame gates this frame, start_mid is driven after line 2
  task automatic send_frame(input logic rgb_mode, input logic start_at_frame,
                            input logic start_mid);
    logic [cam_pkg::raw_w-1:0]  raw [frame_h][frame_w];
    cam_pkg::color_thresholds_t th;
    int r;
    int c;
    th.red_min   = 8'(64 + $urandom_range(127, 0));  // Mid range limits
    th.green_max = 8'(64 + $urandom_range(127, 0));
    th.blue_max  = 8'(64 + $urandom_range(127, 0));
    for (r = 0; r < frame_h; r++) begin
      for (c = 0; c < frame_w; c++) raw[r][c] = cam_pkg::raw_w'($urandom);
    end
    if (!rgb_mode) begin
      raw[0][0] = '0;  // Block 0 is strongly red
      raw[0][1] = '1;
      raw[1][0] = '0;
      raw[1][1] = '0;
      raw[0][2] = '1;  // Block 1 has no red at all
      raw[0][3] = '0;
      raw[1][2] = '1;
      raw[1][3] = '1;
    end
    if (start_at_frame) begin
      for (r = 0; r < frame_h; r += 2) begin
        for (c = 0; c < frame_w; c += 2) begin
          exp_q.push_back(expected_word(raw[r][c], raw[r][c+1], raw[r+1][c],
                                        raw[r+1][c+1], rgb_mode, th));
        end
      end
    end
    @(posedge ccd_pixel_clk);
    mode_rgb          <= rgb_mode;
    start             <= start_at_frame;
    thresholds        <= th;
    pins.frame_valid  <= 1'b0;
    line_gap(2 + $urandom_range(2, 0));
    @(posedge ccd_pixel_clk);
    pins.frame_valid <= 1'b1;
    line_gap(1 + $urandom_range(3, 0));
    for (r = 0; r < frame_h; r++) begin
      for (c = 0; c < frame_w; c++) begin
        @(posedge ccd_pixel_clk);
        pins.line_valid <= 1'b1;
        pins.data       <= raw[r][c];
      end
      line_gap(1 + $urandom_range(3, 0));
      if (r == 2) start <= start_mid;  // Mid-frame change, takes effect next frame
    end
    @(posedge ccd_pixel_clk);
    pins.frame_valid <= 1'b0;
    if (start_at_frame) begin
      exp_frames++;
      end_times.push_back(longint'($time) + count_delay);
    end
    line_gap(3);
    @(negedge ccd_pixel_clk);
    check_count("frame_count", frame_count, exp_frames);
  endtask

  task automatic apply_mid_reset();
    @(posedge ccd_pixel_clk);
    mid_rst <= 1'b1;
    exp_frames = '0;
    end_times.delete();  // Rate windows restart from the release
    repeat (3) @(posedge ccd_pixel_clk);
    mid_rst <= 1'b0;
    @(negedge ccd_pixel_clk);
  endtask

  initial begin
    int total;
    void'($urandom(32'he991fe99));
    pins       <= '0;
    start      <= 1'b0;
    mode_rgb   <= 1'b1;
    frame_size <= '{width: cam_pkg::coord_w'(frame_w), height: cam_pkg::coord_w'(frame_h)};
    thresholds <= '0;
    mid_rst    <= 1'b0;
    wait (!rst);
    @(negedge ccd_pixel_clk);
    check_reset_state();
    repeat (4) send_frame(1'b1, 1'b1, 1'b1);  // RGB555
    repeat (4) send_frame(1'b0, 1'b1, 1'b1);  // Mask
    send_frame(1'b1, 1'b0, 1'b0);             // Start low, nothing written
    send_frame(1'b1, 1'b0, 1'b0);
    send_frame(1'b1, 1'b0, 1'b1);             // Start rises mid-frame
    send_frame(1'b1, 1'b1, 1'b0);             // Captured, start falls mid-frame
    send_frame(1'b1, 1'b0, 1'b0);
    apply_mid_reset();
    check_reset_state();
    send_frame(1'b1, 1'b1, 1'b1);
    send_frame(1'b0, 1'b1, 1'b1);
    send_frame(1'b1, 1'b1, 1'b1);
    repeat (rate_window) @(posedge ccd_pixel_clk);  // One more rate window
    @(negedge ccd_pixel_clk);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("Missing buffer writes: %0d expected words never arrived", exp_q.size());
    end
    total = word_errors + count_errors + flag_errors + other_errors
          + uut.u_checker.assert_fails;
    $display("Error counts: word %0d, count %0d, flag %0d, other %0d, assertion %0d",
             word_errors, count_errors, flag_errors, other_errors,
             uut.u_checker.assert_fails);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // ============================================================
  // Compare process for words, window toggle and rate
  // ============================================================
  always @(negedge ccd_pixel_clk) begin
    longint                t_edge;
    cam_pkg::frame_count_t ended;
    if (rst_prev) live_edges = 0;  // Last edge held the DUT in reset
    else          live_edges++;
    rst_prev = rst;
    if (!rst && fifo_write) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Unexpected buffer write at time %0t, word %h", $time, fifo_word);
      end else begin
        check_word("fifo_word", fifo_word, exp_q.pop_front());
      end
    end
    // Toggle flips once per full window counted from reset release
    check_flag("rate_toggle", rate_toggle, 1'((live_edges / rate_window) % 2));
    if (live_edges > 0 && live_edges % rate_window == 0) begin
      t_edge = longint'($time) - half_period;  // Edge that closed the window
      ended  = '0;
      foreach (end_times[i]) begin
        if (end_times[i] >= t_edge - window_len && end_times[i] < t_edge) ended++;
      end
      check_count("frame_rate", frame_rate, ended);
    end
  end

  // Watchdog
  initial begin
    #(watchdog_time);
    $display("Watchdog timeout: the run did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock and power-on reset
// 10 unit pixel clock, reset held high for the first 4 rising edges

module tb_clock_gen (
  output logic ccd_pixel_clk,
  output logic rst
);

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #5 ccd_pixel_clk = ~ccd_pixel_clk;  // Rising edges at 5, 15, 25 ...
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge ccd_pixel_clk);
    rst <= 1'b0;  // Released on the 4th edge
  end

endmodule

// File: rtl/bayer_demosaic.sv
// Bayer to RGB reconstruction
// Buffers each even raw line and combines every 2x2 G1 R / B G2 block
// into one RGB pixel, so output is half width and half height

module bayer_demosaic (
  input  logic                   ccd_pixel_clk,
  input  logic                   rst,
  input  cam_pkg::bayer_sample_t sample,
  output cam_pkg::rgb_beat_t     beat
);

  // ============================================================
  // Sample decode
  // ============================================================
  logic [cam_pkg::line_addr_w-1:0] wr_addr;   // Column of this sample
  logic [cam_pkg::line_addr_w-1:0] g1_addr;   // Column to the left
  logic                            even_row;
  logic                            odd_col;
  logic                            b_hit;     // B sample on an odd row
  logic                            g2_hit;    // Completes a 2x2 block

  assign wr_addr  = sample.col[cam_pkg::line_addr_w-1:0];
  assign g1_addr  = wr_addr - cam_pkg::line_addr_w'(1);
  assign even_row = ~sample.row[0];
  assign odd_col  = sample.col[0];
  assign b_hit    = sample.valid & ~even_row & ~odd_col;
  assign g2_hit   = sample.valid & ~even_row & odd_col;

  // ============================================================
  // Line buffer, holds G1 and R of the row above
  // ============================================================
  logic [cam_pkg::raw_w-1:0] line_buf [cam_pkg::max_width];

  always_ff @(posedge ccd_pixel_clk) begin
    if (sample.valid && even_row) begin
      line_buf[wr_addr] <= sample.data;  // Every even row sample, G1 and R alike
    end
  end

  // ============================================================
  // Block combine
  // ============================================================
  logic [cam_pkg::raw_w-1:0] b_hold;   // B of the block being finished
  logic [cam_pkg::raw_w-1:0] g1_rd;
  logic [cam_pkg::raw_w-1:0] r_rd;
  logic [cam_pkg::raw_w:0]   g_sum;    // One extra bit for carry

  assign g1_rd = line_buf[g1_addr];
  assign r_rd  = line_buf[wr_addr];    // R sits above G2 in the same column
  assign g_sum = {1'b0, g1_rd} + {1'b0, sample.data};

  always_ff @(posedge ccd_pixel_clk) begin
    if (b_hit) b_hold <= sample.data;
  end

  // ============================================================
  // Output register
  // ============================================================
  logic                beat_valid;
  cam_pkg::rgb_pixel_t pix;

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) beat_valid <= 1'b0;
    else     beat_valid <= g2_hit;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (g2_hit) begin
      pix.red   <= r_rd;
      pix.green <= g_sum[cam_pkg::raw_w:1];  // Mean of G1 and G2, rounded down
      pix.blue  <= b_hold;
    end
  end

  assign beat = '{valid: beat_valid, pixel: pix};

endmodule

// File: rtl/cam_pkg.sv
// Camera pixel path shared definitions
// Widths, sizes and the packed types passed between the stream stages

package cam_pkg;

  // ============================================================
  // Sizes
  // ============================================================
  localparam int raw_w               = 12;          // Sensor sample width
  localparam int coord_w             = 12;          // Column/row counters
  localparam int max_width           = 1280;        // Longest raw line held
  localparam int line_addr_w         = $clog2(max_width);
  localparam int rate_window_default = 96_000_000;  // One second of pixel clocks

  // ============================================================
  // Stream types
  // ============================================================
  typedef struct packed {
    logic [coord_w-1:0] width;   // Raw samples per line
    logic [coord_w-1:0] height;  // Raw lines per frame
  } frame_size_t;

  typedef struct packed {
    logic             frame_valid;
    logic             line_valid;
    logic [raw_w-1:0] data;
  } cam_pins_t;

  // One captured mosaic sample with its position
  typedef struct packed {
    logic               valid;
    logic [raw_w-1:0]   data;
    logic [coord_w-1:0] col;
    logic [coord_w-1:0] row;
  } bayer_sample_t;

  typedef struct packed {
    logic [raw_w-1:0] red;
    logic [raw_w-1:0] green;
    logic [raw_w-1:0] blue;
  } rgb_pixel_t;

  typedef struct packed {
    logic       valid;
    rgb_pixel_t pixel;
  } rgb_beat_t;

  // Colour test limits, compared against the top 8 bits of each component
  typedef struct packed {
    logic [7:0] red_min;
    logic [7:0] green_max;
    logic [7:0] blue_max;
  } color_thresholds_t;

  // ============================================================
  // Buffer word, two readings of the same 16 bits
  // ============================================================
  typedef struct packed {
    logic       zero;  // Always 0
    logic [4:0] red5;
    logic [4:0] green5;
    logic [4:0] blue5;
  } rgb555_t;

  typedef struct packed {
    logic [7:0] zero_byte;
    logic [7:0] mask_byte;  // 0 or 255
  } mask_word_t;

  typedef union packed {
    rgb555_t    rgb555;
    mask_word_t mask;
  } fifo_word_u;

  typedef logic [31:0] frame_count_t;

endpackage

// File: rtl/camera_stream_top.sv
// Camera stream top level
// Capture, demosaic, word packing and frame rate measurement in one domain

module camera_stream_top #(
  parameter int rate_window = cam_pkg::rate_window_default
) (
  input  logic                       ccd_pixel_clk,
  input  logic                       rst,
  input  cam_pkg::cam_pins_t         pins,         // Sensor pins
  input  logic                       start,        // Capture enable, per frame
  input  logic                       mode_rgb,     // Word format select
  input  cam_pkg::frame_size_t       frame_size,
  input  cam_pkg::color_thresholds_t thresholds,
  output cam_pkg::fifo_word_u        fifo_word,
  output logic                       fifo_write,
  output cam_pkg::frame_count_t      frame_count,
  output cam_pkg::frame_count_t      frame_rate,
  output logic                       rate_toggle
);

  // ============================================================
  // Stream links
  // ============================================================
  cam_pkg::bayer_sample_t sample;  // Capture to demosaic
  cam_pkg::rgb_beat_t     beat;    // Demosaic to packer

  ccd_capture u_capture (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .pins          (pins),
    .start         (start),
    .frame_size    (frame_size),
    .sample        (sample),
    .frame_count   (frame_count)
  );

  bayer_demosaic u_demosaic (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .sample        (sample),
    .beat          (beat)
  );

  pixel_packer u_packer (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .beat          (beat),
    .mode_rgb      (mode_rgb),
    .thresholds    (thresholds),
    .fifo_word     (fifo_word),
    .fifo_write    (fifo_write)
  );

  // Rate taken from the same frame counter that leaves the top
  frame_rate_meter #(
    .rate_window (rate_window)
  ) u_rate (
    .ccd_pixel_clk (ccd_pixel_clk),
    .rst           (rst),
    .frame_count   (frame_count),
    .frame_rate    (frame_rate),
    .rate_toggle   (rate_toggle)
  );

endmodule

// File: rtl/ccd_capture.sv
// Camera capture stage
// Registers the sensor pins, gates whole frames with start and tags each
// raw sample with its column and row; also counts captured frames

module ccd_capture (
  input  logic                   ccd_pixel_clk,
  input  logic                   rst,
  input  cam_pkg::cam_pins_t     pins,
  input  logic                   start,
  input  cam_pkg::frame_size_t   frame_size,
  output cam_pkg::bayer_sample_t sample,
  output cam_pkg::frame_count_t  frame_count
);

  // ============================================================
  // Pin registers
  // ============================================================
  logic                        fval_q;   // Registered frame valid
  logic                        lval_q;   // Registered line valid
  logic [cam_pkg::raw_w-1:0]   data_q;
  logic                        fval_d;   // One more stage for edge detect

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      fval_q <= 1'b0;
      lval_q <= 1'b0;
      fval_d <= 1'b0;
    end else begin
      fval_q <= pins.frame_valid;
      lval_q <= pins.line_valid;
      fval_d <= fval_q;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    data_q <= pins.data;
  end

  // ============================================================
  // Frame gating and position counters
  // ============================================================
  logic                        active;     // Capture flag for current frame
  logic [cam_pkg::coord_w-1:0] col;
  logic [cam_pkg::coord_w-1:0] row;
  logic                        fval_rise;
  logic                        fval_fall;
  logic                        active_now;
  logic [cam_pkg::coord_w-1:0] col_now;
  logic [cam_pkg::coord_w-1:0] row_now;
  logic [cam_pkg::coord_w-1:0] last_col;
  logic                        take;       // Sample accepted this cycle

  assign fval_rise  = fval_q & ~fval_d;
  assign fval_fall  = ~fval_q & fval_d;
  // Start is looked at only on the first cycle of a frame
  assign active_now = fval_rise ? start : active;
  assign col_now    = fval_rise ? '0 : col;   // New frame restarts at origin
  assign row_now    = fval_rise ? '0 : row;
  assign last_col   = frame_size.width - cam_pkg::coord_w'(1);
  assign take       = active_now & fval_q & lval_q & (row_now < frame_size.height);

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      active      <= 1'b0;
      col         <= '0;
      row         <= '0;
      frame_count <= '0;
    end else begin
      if (fval_rise) active <= start;
      if (take) begin
        if (col_now == last_col) begin  // Line wrap
          col <= '0;
          row <= row_now + cam_pkg::coord_w'(1);
        end else begin
          col <= col_now + cam_pkg::coord_w'(1);
          row <= row_now;
        end
      end else if (fval_rise) begin
        col <= '0;
        row <= '0;
      end
      // Count on frame end, only if this frame was gated in
      if (fval_fall && active) frame_count <= frame_count + 32'd1;
    end
  end

  // ============================================================
  // Sample output register
  // ============================================================
  logic                        smp_valid;
  logic [cam_pkg::raw_w-1:0]   smp_data;
  logic [cam_pkg::coord_w-1:0] smp_col;
  logic [cam_pkg::coord_w-1:0] smp_row;

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) smp_valid <= 1'b0;
    else     smp_valid <= take;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    smp_data <= data_q;
    smp_col  <= col_now;
    smp_row  <= row_now;
  end

  assign sample = '{valid: smp_valid, data: smp_data, col: smp_col, row: smp_row};

endmodule

// File: rtl/frame_rate_meter.sv
// Frame rate meter
// Counts captured frames per fixed window of pixel clocks

module frame_rate_meter #(
  parameter int rate_window = cam_pkg::rate_window_default  // Pixel clocks per window
) (
  input  logic                  ccd_pixel_clk,
  input  logic                  rst,
  input  cam_pkg::frame_count_t frame_count,
  output cam_pkg::frame_count_t frame_rate,
  output logic                  rate_toggle   // Flips at every window end
);

  // ============================================================
  // Window timer
  // ============================================================
  logic [31:0] win_cnt;
  logic        win_end;

  assign win_end = (win_cnt == 32'(rate_window - 1));

  // ============================================================
  // Rate capture
  // ============================================================
  cam_pkg::frame_count_t count_saved;  // frame_count at last window end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) begin
      win_cnt     <= '0;
      count_saved <= '0;
      frame_rate  <= '0;
      rate_toggle <= 1'b0;
    end else if (win_end) begin
      win_cnt     <= '0;
      frame_rate  <= frame_count - count_saved;  // Frames ended inside the window
      count_saved <= frame_count;
      rate_toggle <= ~rate_toggle;
    end else begin
      win_cnt <= win_cnt + 32'd1;
    end
  end

endmodule

// File: rtl/pixel_packer.sv
// Buffer word packer
// Packs each RGB pixel as RGB555 or as a red-object mask byte

module pixel_packer (
  input  logic                       ccd_pixel_clk,
  input  logic                       rst,
  input  cam_pkg::rgb_beat_t         beat,
  input  logic                       mode_rgb,    // 1 = RGB555, 0 = mask
  input  cam_pkg::color_thresholds_t thresholds,
  output cam_pkg::fifo_word_u        fifo_word,
  output logic                       fifo_write
);

  // ============================================================
  // Colour test on the top byte of each component
  // ============================================================
  logic [7:0] red8;
  logic [7:0] green8;
  logic [7:0] blue8;
  logic       is_red;

  assign red8   = beat.pixel.red[cam_pkg::raw_w-1 -: 8];
  assign green8 = beat.pixel.green[cam_pkg::raw_w-1 -: 8];
  assign blue8  = beat.pixel.blue[cam_pkg::raw_w-1 -: 8];
  assign is_red = (red8 >= thresholds.red_min) && (green8 <= thresholds.green_max)
               && (blue8 <= thresholds.blue_max);

  // ============================================================
  // Word select and output register
  // ============================================================
  cam_pkg::fifo_word_u word_next;

  always_comb begin
    word_next = '0;  // Unused high bits stay clear in both views
    if (mode_rgb) begin
      word_next.rgb555.red5   = beat.pixel.red[cam_pkg::raw_w-1 -: 5];
      word_next.rgb555.green5 = beat.pixel.green[cam_pkg::raw_w-1 -: 5];
      word_next.rgb555.blue5  = beat.pixel.blue[cam_pkg::raw_w-1 -: 5];
    end else begin
      word_next.mask.mask_byte = is_red ? 8'hff : 8'h00;
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (beat.valid) fifo_word <= word_next;  // Mode taken with the beat
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (rst) fifo_write <= 1'b0;
    else     fifo_write <= beat.valid;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the camera stream testbench with Verilator.
# The run counts as passed only if the pass line appears in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module camera_stream_tb -Mdir obj_dir -f vlog.f \
  && ./obj_dir/Vcamera_stream_tb +verilator+error+limit+100 \
    | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
  && echo "run_sim: simulation passed" \
  || { echo "run_sim: simulation failed"; exit 1; }

// File: vlog.f
rtl/cam_pkg.sv
rtl/ccd_capture.sv
rtl/bayer_demosaic.sv
rtl/pixel_packer.sv
rtl/frame_rate_meter.sv
rtl/camera_stream_top.sv
dv/tb_clock_gen.sv
dv/camera_stream_checker.sv
dv/camera_stream_tb.sv
